/* src/lfb_pkg.sv */
//============================
// Line fill buffer package
// Widths, types, bus codes and FSM states
//============================
package lfb_pkg;

  //============================
  // Widths
  //============================
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_BEATS = 8;
  localparam int OFFSET_W   = 3;
  localparam int PTR_W      = 3;
  // Line index sits right above the word offset and byte bits
  localparam int INDEX_LO   = 5;
  localparam int INDEX_W    = 10;
  // Address bits 31 to 15
  localparam int TAG_W      = 17;
  localparam int DATA_IDX_W = 12;

  //============================
  // Types
  //============================
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  // Line index plus offset bits 2 to 1
  typedef logic [DATA_IDX_W-1:0] data_idx_t;
  typedef logic [2*WORD_W-1:0]   dword_t;
  typedef logic [1:0]            size_t;
  typedef logic [2:0]            burst_t;

  // Bus codes
  localparam burst_t BURST_SINGLE = 3'b000;
  localparam burst_t BURST_WRAP8  = 3'b100;
  localparam size_t  SIZE_WORD    = 2'b10;

  // Main fill FSM
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WFC,
    REF
  } fill_state_e;

endpackage

/* src/fill_beat_if.sv */
//============================
// Refill beat stream
//============================
`timescale 1ns/1ps

interface fill_beat_if;
  import lfb_pkg::*;

  logic    valid;
  logic    ready;
  word_t   data;
  offset_t offset;
  logic    first;
  logic    last;
  logic    err;

  // Fill control side
  modport src (output valid, data, offset, first, last, err, input ready);
  // Buffer input, ready tied off at top
  modport buf_in (input valid, data, offset, first, last, err);
  modport buf_out (output valid, data, offset, first, last, err, input ready);
  // Array writer side
  modport sink (input valid, data, offset, first, last, err, output ready);

endinterface

/* src/lfb_fill_ctrl.sv */
//============================
// Line fill buffer control
// Request capture, bus request, beat counting, load completion
//============================
`timescale 1ns/1ps

module lfb_fill_ctrl (
  input  logic            lfb_fsm_clk,
  input  logic            cpurst_b,
  input  logic            flush,
  input  logic            create_en,
  input  lfb_pkg::addr_t  create_addr,
  input  logic            create_ca,
  input  lfb_pkg::size_t  create_size,
  input  logic            create_ld,
  input  lfb_pkg::addr_t  probe_addr,
  input  logic            bus_grant,
  input  logic            bus_cmplt,
  input  logic            bus_err,
  input  lfb_pkg::word_t  bus_data,
  input  logic            line_done,
  output logic            bus_req,
  output lfb_pkg::addr_t  bus_addr,
  output lfb_pkg::size_t  bus_size,
  output lfb_pkg::burst_t bus_burst,
  output logic            ld_cmplt,
  output lfb_pkg::word_t  ld_data,
  output logic            async_expt,
  output logic            busy,
  output logic            idle,
  output logic            hit_idx,
  output logic            stb_done,
  output logic            stb_err,
  output logic            pop_en,
  output lfb_pkg::index_t held_index,
  output lfb_pkg::tag_t   held_tag,
  fill_beat_if.src        beat
);
  import lfb_pkg::*;

  fill_state_e state;
  fill_state_e next_state;

  addr_t   req_addr;
  size_t   req_size;
  logic    req_ca;
  logic    req_ld;
  offset_t beat_cnt;
  offset_t start_word;
  logic    err_flag;
  logic    beat_fire;
  logic    ld_capture;
  logic    in_wfc;
  logic    in_ref;

  //============================
  // Main FSM
  //============================
  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state <= IDLE;
    end else if (flush) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: if (create_en) next_state = REQ;
      REQ:  if (bus_grant) next_state = WFC;
      // Single beat, error beat or eighth beat ends the bus phase
      WFC: begin
        if (bus_cmplt & (~req_ca | bus_err | (beat_cnt == offset_t'(LINE_BEATS - 1)))) begin
          next_state = REF;
        end
      end
      REF:  if (~req_ca | line_done) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  assign in_wfc = (state == WFC);
  assign in_ref = (state == REF);

  // Request capture
  always_ff @(posedge lfb_fsm_clk) begin
    if (create_en & (state == IDLE)) begin
      req_addr <= create_addr;
      req_size <= create_size;
    end
  end

  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      req_ca   <= 1'b0;
      req_ld   <= 1'b0;
      beat_cnt <= '0;
      err_flag <= 1'b0;
      ld_cmplt <= 1'b0;
    end else if (flush) begin
      req_ca   <= 1'b0;
      req_ld   <= 1'b0;
      beat_cnt <= '0;
      err_flag <= 1'b0;
      ld_cmplt <= 1'b0;
    end else begin
      if (create_en & (state == IDLE)) begin
        req_ca <= create_ca;
        req_ld <= create_ld;
      end
      if (state == IDLE) begin
        beat_cnt <= '0;
        err_flag <= 1'b0;
      end else if (beat_fire) begin
        beat_cnt <= beat_cnt + offset_t'(1);
        err_flag <= err_flag | bus_err;
      end
      ld_cmplt <= ld_capture & req_ld;
    end
  end

  //============================
  // Bus request and beat stream
  //============================
  assign bus_req   = (state == REQ);
  assign bus_addr  = req_ca ? {req_addr[ADDR_W-1:2], 2'b00} : req_addr;
  assign bus_size  = req_ca ? SIZE_WORD : req_size;
  assign bus_burst = req_ca ? BURST_WRAP8 : BURST_SINGLE;

  assign start_word = req_addr[INDEX_LO-1 -: OFFSET_W];
  assign beat_fire  = in_wfc & bus_cmplt & req_ca;

  // Wrapped offset follows the burst order
  assign beat.valid  = beat_fire;
  assign beat.data   = bus_data;
  assign beat.offset = start_word + beat_cnt;
  assign beat.first  = (beat_cnt == '0);
  assign beat.last   = (beat_cnt == offset_t'(LINE_BEATS - 1));
  assign beat.err    = bus_err;

  //============================
  // Load completion
  //============================
  // Critical word is the first beat of a cacheable burst
  assign ld_capture = in_wfc & bus_cmplt & (~req_ca | (beat_cnt == '0));

  always_ff @(posedge lfb_fsm_clk) begin
    if (ld_capture) begin
      ld_data <= bus_data;
    end
  end

  assign async_expt = in_wfc & bus_cmplt & bus_err & req_ld;

  //============================
  // Status and store buffer
  //============================
  assign idle       = (state == IDLE);
  assign busy       = ~idle;
  assign held_index = req_addr[INDEX_LO +: INDEX_W];
  assign held_tag   = req_addr[ADDR_W-1 -: TAG_W];
  assign hit_idx    = (probe_addr[INDEX_LO +: INDEX_W] == held_index) & busy & req_ca;

  assign stb_done = in_ref & req_ca & line_done & ~err_flag;
  assign stb_err  = in_ref & req_ca & line_done & err_flag;
  assign pop_en   = in_ref & (~req_ca | line_done);

endmodule

/* src/lfb_beat_fifo.sv */
//============================
// Refill beat buffer
// Decouples bus beats from array writes
//============================
`timescale 1ns/1ps

module lfb_beat_fifo (
  input  logic        lfb_fsm_clk,
  input  logic        cpurst_b,
  input  logic        flush,
  fill_beat_if.buf_in  wr,
  fill_beat_if.buf_out rd
);
  import lfb_pkg::*;

  // Beat storage
  word_t   mem_data  [LINE_BEATS];
  offset_t mem_offset[LINE_BEATS];
  logic [LINE_BEATS-1:0] mem_first;
  logic [LINE_BEATS-1:0] mem_last;
  logic [LINE_BEATS-1:0] mem_err;

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = count[PTR_W];
  assign push = wr.valid & ~full;
  assign pop  = rd.valid & rd.ready;

  always_ff @(posedge lfb_fsm_clk) begin
    if (push) begin
      mem_data[wr_ptr]   <= wr.data;
      mem_offset[wr_ptr] <= wr.offset;
      mem_first[wr_ptr]  <= wr.first;
      mem_last[wr_ptr]   <= wr.last;
      mem_err[wr_ptr]    <= wr.err;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Oldest beat held until taken
  assign rd.valid  = (count != '0);
  assign rd.data   = mem_data[rd_ptr];
  assign rd.offset = mem_offset[rd_ptr];
  assign rd.first  = mem_first[rd_ptr];
  assign rd.last   = mem_last[rd_ptr];
  assign rd.err    = mem_err[rd_ptr];

endmodule

/* src/lfb_array_writer.sv */
//============================
// Cache array writer
// Tag and data writes for buffered refill beats
//============================
`timescale 1ns/1ps

module lfb_array_writer (
  input  logic                 lfb_fsm_clk,
  input  logic                 cpurst_b,
  input  logic                 flush,
  input  lfb_pkg::index_t      held_index,
  input  lfb_pkg::tag_t        held_tag,
  input  logic                 array_ready,
  fill_beat_if.sink            beat,
  output logic                 tag_req,
  output lfb_pkg::index_t      tag_idx,
  output logic [lfb_pkg::TAG_W:0] tag_din,
  output logic                 data_req,
  output lfb_pkg::data_idx_t   data_idx,
  output logic [1:0]           data_bank,
  output lfb_pkg::dword_t      data_din,
  output logic                 line_done
);
  import lfb_pkg::*;

  // Final tag write with the valid bit set is pending
  logic fin_pend;
  logic beat_good;
  logic beat_take;

  assign beat_good = beat.valid & ~beat.err & ~fin_pend;

  // Error beats drain without touching the arrays
  assign beat.ready = ~fin_pend & (beat.err | array_ready);
  assign beat_take  = beat.valid & beat.ready;

  //============================
  // Tag array
  //============================
  // First beat clears valid, final write sets it
  assign tag_req = fin_pend | (beat_good & beat.first);
  assign tag_idx = held_index;
  assign tag_din = {fin_pend, held_tag};

  //============================
  // Data array
  //============================
  assign data_req  = beat_good;
  assign data_idx  = {held_index, beat.offset[OFFSET_W-1:1]};
  assign data_bank = {beat.offset[0], ~beat.offset[0]};
  // Same word in both halves, bank picks the half
  assign data_din  = {beat.data, beat.data};

  always_ff @(posedge lfb_fsm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      fin_pend  <= 1'b0;
      line_done <= 1'b0;
    end else if (flush) begin
      fin_pend  <= 1'b0;
      line_done <= 1'b0;
    end else begin
      line_done <= (fin_pend & array_ready) | (beat_take & beat.err);
      if (beat_take & beat.last & ~beat.err) begin
        fin_pend <= 1'b1;
      end else if (fin_pend & array_ready) begin
        fin_pend <= 1'b0;
      end
    end
  end

endmodule

/* src/lfb_top.sv */
//============================
// Line fill buffer top
// Fill control, beat buffer and array writer
//============================
`timescale 1ns/1ps

module lfb_top (
  input  logic                    lfb_fsm_clk,
  input  logic                    cpurst_b,
  input  logic                    flush,
  // Cache request side
  input  logic                    create_en,
  input  lfb_pkg::addr_t          create_addr,
  input  logic                    create_ca,
  input  lfb_pkg::size_t          create_size,
  input  logic                    create_ld,
  input  lfb_pkg::addr_t          probe_addr,
  // Bus side
  input  logic                    bus_grant,
  input  logic                    bus_cmplt,
  input  logic                    bus_err,
  input  lfb_pkg::word_t          bus_data,
  output logic                    bus_req,
  output lfb_pkg::addr_t          bus_addr,
  output lfb_pkg::size_t          bus_size,
  output lfb_pkg::burst_t         bus_burst,
  // Load and store buffer status
  output logic                    ld_cmplt,
  output lfb_pkg::word_t          ld_data,
  output logic                    async_expt,
  output logic                    busy,
  output logic                    idle,
  output logic                    hit_idx,
  output logic                    stb_done,
  output logic                    stb_err,
  output logic                    pop_en,
  // Cache arrays
  input  logic                    array_ready,
  output logic                    tag_req,
  output lfb_pkg::index_t         tag_idx,
  output logic [lfb_pkg::TAG_W:0] tag_din,
  output logic                    data_req,
  output lfb_pkg::data_idx_t      data_idx,
  output logic [1:0]              data_bank,
  output lfb_pkg::dword_t         data_din
);
  import lfb_pkg::*;

  index_t held_index;
  tag_t   held_tag;
  logic   line_done;

  fill_beat_if beat_in ();
  fill_beat_if beat_out ();

  // Buffer holds a full line, so the bus side never stalls
  assign beat_in.ready = 1'b1;

  lfb_fill_ctrl u_fill_ctrl (
    .lfb_fsm_clk (lfb_fsm_clk), .cpurst_b (cpurst_b), .flush (flush),
    .create_en (create_en), .create_addr (create_addr), .create_ca (create_ca),
    .create_size (create_size), .create_ld (create_ld), .probe_addr (probe_addr),
    .bus_grant (bus_grant), .bus_cmplt (bus_cmplt), .bus_err (bus_err),
    .bus_data (bus_data), .line_done (line_done), .bus_req (bus_req),
    .bus_addr (bus_addr), .bus_size (bus_size), .bus_burst (bus_burst),
    .ld_cmplt (ld_cmplt), .ld_data (ld_data), .async_expt (async_expt),
    .busy (busy), .idle (idle), .hit_idx (hit_idx), .stb_done (stb_done),
    .stb_err (stb_err), .pop_en (pop_en), .held_index (held_index),
    .held_tag (held_tag), .beat (beat_in.src)
  );

  lfb_beat_fifo u_beat_fifo (
    .lfb_fsm_clk (lfb_fsm_clk), .cpurst_b (cpurst_b), .flush (flush),
    .wr (beat_in.buf_in), .rd (beat_out.buf_out)
  );

  lfb_array_writer u_array_writer (
    .lfb_fsm_clk (lfb_fsm_clk), .cpurst_b (cpurst_b), .flush (flush),
    .held_index (held_index), .held_tag (held_tag), .array_ready (array_ready),
    .beat (beat_out.sink), .tag_req (tag_req), .tag_idx (tag_idx),
    .tag_din (tag_din), .data_req (data_req), .data_idx (data_idx),
    .data_bank (data_bank), .data_din (data_din), .line_done (line_done)
  );

endmodule

/* verification/lfb_props.sv */
//============================
// Fill buffer protocol checks
//============================
`timescale 1ns/1ps

module lfb_props (
  input logic                  lfb_fsm_clk,
  input logic                  cpurst_b,
  input lfb_pkg::fill_state_e  fsm_state,
  input logic                  idle,
  input logic                  bus_req,
  input logic                  ld_cmplt,
  input logic                  array_ready,
  input logic                  tag_req,
  input lfb_pkg::index_t       tag_idx,
  input logic [lfb_pkg::TAG_W:0] tag_din,
  input logic                  data_req,
  input lfb_pkg::data_idx_t    data_idx,
  input logic [1:0]            data_bank,
  input lfb_pkg::dword_t       data_din
);
  import lfb_pkg::*;

  // No bus request while idle
  req_not_idle: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    idle |-> !bus_req) else $error("bus_req high while idle");

  // Buffered beats drain before the FSM returns to idle
  wr_in_fill: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    (tag_req || data_req) |-> (fsm_state inside {WFC, REF}))
    else $error("array write outside a fill");

  ld_pulse: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    ld_cmplt |=> !ld_cmplt) else $error("ld_cmplt high for two cycles");

  // Array requests wait for array_ready
  tag_hold: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    (tag_req && !array_ready) |=> (tag_req && $stable({tag_idx, tag_din})))
    else $error("tag write dropped or changed under back-pressure");
  data_hold: assert property (@(posedge lfb_fsm_clk) disable iff (!cpurst_b)
    (data_req && !array_ready) |=> (data_req && $stable({data_idx, data_bank, data_din})))
    else $error("data write dropped or changed under back-pressure");

endmodule

bind lfb_top lfb_props u_props (
  .lfb_fsm_clk (lfb_fsm_clk), .cpurst_b (cpurst_b), .fsm_state (u_fill_ctrl.state),
  .idle (idle), .bus_req (bus_req), .ld_cmplt (ld_cmplt), .array_ready (array_ready),
  .tag_req (tag_req), .tag_idx (tag_idx), .tag_din (tag_din), .data_req (data_req),
  .data_idx (data_idx), .data_bank (data_bank), .data_din (data_din)
);

/* verification/lfb_tb.sv */
//============================
// Line fill buffer testbench
// Random requests, bus and array models, reference checks
//============================
`timescale 1ns/1ps

module lfb_tb;
  import lfb_pkg::*;

  logic lfb_fsm_clk = 1'b0;
  logic cpurst_b, flush, create_en, create_ca, create_ld;
  addr_t create_addr, probe_addr;
  size_t create_size;
  logic bus_grant = 1'b0;
  logic bus_cmplt = 1'b0;
  logic bus_err = 1'b0;
  word_t bus_data = '0;
  logic array_ready = 1'b0;
  logic bus_req, ld_cmplt, async_expt, busy, idle, hit_idx, stb_done, stb_err, pop_en;
  addr_t bus_addr;
  size_t bus_size;
  burst_t bus_burst;
  word_t ld_data;
  logic tag_req, data_req;
  index_t tag_idx;
  logic [TAG_W:0] tag_din;
  data_idx_t data_idx;
  logic [1:0] data_bank;
  dword_t data_din;

  int seed;
  // Bus model
  int bus_mode = 0;
  int beat_no = 0;
  int beat_now = -1;
  int err_beat = -1;
  addr_t burst_addr = '0;
  logic burst_single = 1'b0;
  // Reference model
  logic [INDEX_W+TAG_W:0] exp_tag_q[$];
  logic [DATA_IDX_W+2+2*WORD_W-1:0] exp_data_q[$];
  word_t exp_ld;
  logic cur_ca, cur_ld;
  int prev_beat = -1;
  int ld_cnt = 0;
  int done_cnt = 0;
  int err_cnt = 0;
  int pop_cnt = 0;
  int expt_cnt = 0;
  int k;

  lfb_top DUT (.*);

  always #10 lfb_fsm_clk = ~lfb_fsm_clk;

  function automatic word_t beat_word(input addr_t a, input int n);
    beat_word = (a ^ 32'h6c8e_9cf5) + (32'h0101_0101 * word_t'(n));
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH at time %0t: %s is %0h, expected %0h",
                               $time, what, actual, expected));
    end
  endtask

  //============================
  // Bus and array models
  //============================
  always @(negedge lfb_fsm_clk) begin
    bus_grant = 1'b0;
    bus_cmplt = 1'b0;
    bus_err = 1'b0;
    beat_now = -1;
    array_ready = (($random(seed) & 3) != 0);
    if (bus_mode == 0) begin
      if (bus_req && (($random(seed) & 3) == 0)) begin
        bus_grant = 1'b1;
        burst_addr = bus_addr;
        burst_single = (bus_burst == BURST_SINGLE);
        beat_no = 0;
        bus_mode = 1;
      end
    end else if (($random(seed) & 1) == 0) begin
      bus_cmplt = 1'b1;
      bus_data = beat_word(burst_addr, beat_no);
      bus_err = (beat_no == err_beat);
      beat_now = beat_no;
      beat_no = beat_no + 1;
      if (burst_single || bus_err || beat_no == LINE_BEATS) bus_mode = 0;
    end
  end

  // Monitor samples after the falling edge inputs settle
  always @(negedge lfb_fsm_clk) begin
    #2;
    if (cpurst_b) begin
      if (tag_req && array_ready) begin
        if (exp_tag_q.size() == 0) report_failure("Unexpected tag array write");
        else check_value(128'({tag_idx, tag_din}), 128'(exp_tag_q.pop_front()), "tag write");
      end
      if (data_req && array_ready) begin
        if (exp_data_q.size() == 0) report_failure("Unexpected data array write");
        else check_value(128'({data_idx, data_bank, data_din}),
                         128'(exp_data_q.pop_front()), "data write");
      end
      if (ld_cmplt) begin
        check_value(128'(prev_beat), 128'(0), "beat index before ld_cmplt");
        check_value(128'(ld_data), 128'(exp_ld), "ld_data");
        ld_cnt = ld_cnt + 1;
      end
      if (async_expt) begin
        check_value(128'(bus_err & cur_ld), 128'(1), "async_expt with error beat");
        expt_cnt = expt_cnt + 1;
      end
      if (stb_done || stb_err) begin
        check_value(128'(exp_tag_q.size() + exp_data_q.size()), 128'(0), "writes left at end");
        done_cnt = done_cnt + (stb_done ? 1 : 0);
        err_cnt = err_cnt + (stb_err ? 1 : 0);
      end
      if (pop_en) begin
        if (cur_ca) check_value(128'(stb_done | stb_err), 128'(1), "pop_en with line end");
        else check_value(128'(prev_beat), 128'(0), "beat index before pop_en");
        pop_cnt = pop_cnt + 1;
      end
    end
    prev_beat = beat_now;
  end

  task automatic wait_bus_req();
    int n;
    n = 0;
    while (bus_req !== 1'b1) begin
      @(negedge lfb_fsm_clk);
      #5;
      n = n + 1;
      if (n > 100) report_failure("Timeout: no bus request after create");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (idle !== 1'b1) begin
      @(negedge lfb_fsm_clk);
      #5;
      n = n + 1;
      if (n > 600) report_failure("Timeout: fill buffer never returned to idle");
    end
  endtask

  //============================
  // One miss request
  //============================
  task automatic run_request(input logic ca, input logic ld, input int err_b);
    addr_t a, wa;
    size_t sz;
    index_t idx;
    tag_t tg;
    offset_t start, off;
    word_t w;
    int n, ld0, done0, err0, pop0, expt0;
    @(posedge lfb_fsm_clk);
    a = addr_t'($random(seed));
    sz = ca ? SIZE_WORD : size_t'($random(seed));
    if (sz == 2'b11) sz = SIZE_WORD;
    wa = ca ? {a[31:2], 2'b00} : a;
    idx = a[14:5];
    tg = a[31:15];
    start = a[4:2];
    exp_ld = beat_word(wa, 0);
    cur_ca = ca;
    cur_ld = ld;
    err_beat = err_b;
    if (ca) begin
      for (n = 0; n < LINE_BEATS; n++) begin
        if (n == err_b) break;
        if (n == 0) exp_tag_q.push_back({idx, 1'b0, tg});
        off = start + offset_t'(n);
        w = beat_word(wa, n);
        exp_data_q.push_back({idx, off[2:1], (off[0] ? 2'b10 : 2'b01), w, w});
      end
      if (err_b < 0) exp_tag_q.push_back({idx, 1'b1, tg});
    end
    ld0 = ld_cnt;
    done0 = done_cnt;
    err0 = err_cnt;
    pop0 = pop_cnt;
    expt0 = expt_cnt;
    @(negedge lfb_fsm_clk);
    create_en = 1'b1;
    create_addr = a;
    create_ca = ca;
    create_size = sz;
    create_ld = ld;
    @(negedge lfb_fsm_clk);
    create_en = 1'b0;
    wait_bus_req();
    check_value(128'(bus_addr), 128'(wa), "bus_addr");
    check_value(128'(bus_size), 128'(sz), "bus_size");
    check_value(128'(bus_burst), 128'(ca ? BURST_WRAP8 : BURST_SINGLE), "bus_burst");
    if (ca) begin
      check_value(128'({busy, idle}), 128'(2'b10), "busy and idle during fill");
      @(negedge lfb_fsm_clk);
      probe_addr = a ^ 32'h8000_0000;
      #5;
      check_value(128'(hit_idx), 128'(1), "hit_idx for same index");
      @(negedge lfb_fsm_clk);
      probe_addr = a ^ 32'h0000_0020;
      #5;
      check_value(128'(hit_idx), 128'(0), "hit_idx for other index");
    end
    wait_idle();
    check_value(128'(ld_cnt - ld0), 128'(ld ? 1 : 0), "load completions");
    check_value(128'(done_cnt - done0), 128'((ca && err_b < 0) ? 1 : 0), "stb_done pulses");
    check_value(128'(err_cnt - err0), 128'((ca && err_b >= 0) ? 1 : 0), "stb_err pulses");
    check_value(128'(pop_cnt - pop0), 128'(1), "pop_en pulses");
    check_value(128'(expt_cnt - expt0), 128'((ld && err_b >= 0) ? 1 : 0), "async_expt");
  endtask

  initial begin
    seed = 32'h4269_20f0;
    cpurst_b = 1'b0;
    flush = 1'b0;
    create_en = 1'b0;
    create_addr = '0;
    create_ca = 1'b0;
    create_size = '0;
    create_ld = 1'b0;
    probe_addr = '0;
    cur_ca = 1'b0;
    cur_ld = 1'b0;
    exp_ld = '0;
    repeat (8) @(negedge lfb_fsm_clk);
    cpurst_b = 1'b1;
    run_request(1'b0, 1'b1, -1);
    run_request(1'b0, 1'b0, -1);
    run_request(1'b1, 1'b1, -1);
    run_request(1'b1, 1'b0, -1);
    // Random mix under random array back-pressure
    for (int i = 0; i < 12; i++) begin
      k = $random(seed);
      run_request(k[0], k[1], -1);
    end
    run_request(1'b1, 1'b1, 3);
    run_request(1'b1, 1'b0, 5);
    run_request(1'b1, 1'b1, 0);
    run_request(1'b1, 1'b1, -1);
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* flist.f */
src/lfb_pkg.sv
src/fill_beat_if.sv
src/lfb_fill_ctrl.sv
src/lfb_beat_fifo.sv
src/lfb_array_writer.sv
src/lfb_top.sv
verification/lfb_props.sv
verification/lfb_tb.sv

/* Makefile */
# Verilator build and run for the line fill buffer testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module lfb_tb -Mdir obj_dir

# The log decides pass or fail
run: compile
	./obj_dir/Vlfb_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
